// ==== hw/shifter_pkg.sv ====
/*
 * Shared types and constants of the video shifter.
 * Every RTL block and the testbench import this package with a wildcard import.
 * Holds the mode encoding, colour and bus structs, and the power-up palette.
 */
`default_nettype none

package shifter_pkg;

  // screen modes, value 3 is treated as mono everywhere
  typedef enum logic [1:0] {
    MODE_LOW  = 2'd0,
    MODE_MED  = 2'd1,
    MODE_MONO = 2'd2
  } shmode_t;

  // 3 bits per channel, as in the palette registers
  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [2:0] b;
  } rgb_t;

  typedef rgb_t [15:0] palette_t;
  typedef logic [3:0]  color_idx_t;

  // video memory word address and data
  typedef logic [22:0] vaddr_t;
  typedef logic [15:0] word_t;

  // one cpu register access, strobes active low
  typedef struct packed {
    logic       sel;
    logic       rw;
    logic [5:0] addr;
    logic       uds;
    logic       lds;
    word_t      din;
  } reg_bus_t;

  // raster position and window flags
  typedef struct packed {
    logic [9:0] hcnt;
    logic [9:0] vcnt;
    logic       de;
    logic       line_end;
    logic       frame_end;
  } raster_t;

  // one low res group, fetch runs this far ahead of display
  localparam int FETCH_LEAD = 32;

  // entry 15 first, each entry written as octal rgb
  localparam palette_t DEFAULT_PALETTE = {
    9'o000, 9'o377, 9'o737, 9'o337,
    9'o773, 9'o373, 9'o733, 9'o333,
    9'o555, 9'o077, 9'o707, 9'o007,
    9'o770, 9'o070, 9'o700, 9'o777
  };

  // register map, word addresses on the cpu side
  localparam logic [5:0] REG_BASE_HI   = 6'h00;
  localparam logic [5:0] REG_BASE_LO   = 6'h01;
  localparam logic [5:0] REG_VADDR_HI  = 6'h02;
  localparam logic [5:0] REG_VADDR_MID = 6'h03;
  localparam logic [5:0] REG_VADDR_LO  = 6'h04;
  localparam logic [5:0] REG_PAL_FIRST = 6'h20;
  localparam logic [5:0] REG_MODE      = 6'h30;

endpackage

`default_nettype wire

// ==== hw/shifter_regs.sv ====
/*
 * CPU side register file of the shifter.
 * Holds video base, written screen mode and the 16 entry palette,
 * honours the byte lane strobes and returns a combinational readback.
 * The active mode follows the written one only at frame end.
 */
`default_nettype none

module shifter_regs import shifter_pkg::*; #(
  parameter vaddr_t  BASE_ADDR    = 23'h8000,
  parameter shmode_t DEFAULT_MODE = MODE_MONO
) (
  input  logic     clk,
  input  logic     ss,
  input  reg_bus_t reg_bus,
  input  vaddr_t   vaddr,
  input  logic     frame_end,
  output word_t    reg_dout,
  output vaddr_t   base_addr,
  output shmode_t  mode,
  output palette_t palette
);

  // base bits 22..7, the low bits are always zero
  logic [15:0] base_q;
  shmode_t     mode_wr;
  logic        wr;
  logic        pal_hit;
  logic [3:0]  pal_idx;

  assign wr      = reg_bus.sel && !reg_bus.rw;
  // 0x20..0x2f
  assign pal_hit = reg_bus.addr[5:4] == REG_PAL_FIRST[5:4];
  assign pal_idx = reg_bus.addr[3:0];

  assign base_addr = {base_q, 7'd0};

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      base_q  <= BASE_ADDR[22:7];
      mode_wr <= DEFAULT_MODE;
      mode    <= DEFAULT_MODE;
      palette <= DEFAULT_PALETTE;
    end else begin
      if (wr && reg_bus.addr == REG_BASE_HI && !reg_bus.lds) begin
        base_q[15:8] <= reg_bus.din[7:0];
      end
      if (wr && reg_bus.addr == REG_BASE_LO && !reg_bus.lds) begin
        base_q[7:0] <= reg_bus.din[7:0];
      end
      if (wr && reg_bus.addr == REG_MODE && !reg_bus.uds) begin
        mode_wr <= shmode_t'(reg_bus.din[9:8]);
      end
      // red on the upper lane, green and blue on the lower
      if (wr && pal_hit && !reg_bus.uds) begin
        palette[pal_idx].r <= reg_bus.din[10:8];
      end
      if (wr && pal_hit && !reg_bus.lds) begin
        palette[pal_idx].g <= reg_bus.din[6:4];
        palette[pal_idx].b <= reg_bus.din[2:0];
      end
      // new mode only between frames
      if (frame_end) begin
        mode <= mode_wr;
      end
    end
  end

  // readback mirrors the write field positions
  always_comb begin
    reg_dout = '0;
    if (reg_bus.sel && reg_bus.rw) begin
      if (pal_hit) begin
        reg_dout[10:8] = palette[pal_idx].r;
        reg_dout[6:4]  = palette[pal_idx].g;
        reg_dout[2:0]  = palette[pal_idx].b;
      end else begin
        case (reg_bus.addr)
          REG_BASE_HI: begin
            if (!reg_bus.lds) reg_dout = {8'h00, base_q[15:8]};
          end
          REG_BASE_LO: begin
            if (!reg_bus.lds) reg_dout = {8'h00, base_q[7:0]};
          end
          REG_VADDR_HI: begin
            if (!reg_bus.lds) reg_dout = {8'h00, vaddr[22:15]};
          end
          REG_VADDR_MID: begin
            if (!reg_bus.lds) reg_dout = {8'h00, vaddr[14:7]};
          end
          // byte address view of the low word bits
          REG_VADDR_LO: begin
            if (!reg_bus.lds) reg_dout = {8'h00, vaddr[6:0], 1'b0};
          end
          REG_MODE: begin
            if (!reg_bus.uds) reg_dout = {6'h00, mode_wr, 8'h00};
          end
          default: reg_dout = '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/raster_timing.sv ====
/*
 * Raster timing generator.
 * Counts pixels and lines, opens the display window FETCH_LEAD clocks
 * behind the fetch window, and gives sync levels and end pulses.
 */
`default_nettype none

module raster_timing import shifter_pkg::*; #(
  parameter int H_ACT = 640,
  parameter int H_FP  = 24,
  parameter int H_S   = 40,
  parameter int H_BP  = 128,
  parameter int V_ACT = 400,
  parameter int V_FP  = 55,
  parameter int V_S   = 3,
  parameter int V_BP  = 73
) (
  input  logic    clk,
  input  logic    ss,
  output raster_t raster,
  output logic    hs_raw,
  output logic    vs_raw
);

  localparam int H_TOT = H_ACT + H_FP + H_S + H_BP;
  localparam int V_TOT = V_ACT + V_FP + V_S + V_BP;
  localparam logic [9:0] H_LAST   = 10'(H_TOT - 1);
  localparam logic [9:0] V_LAST   = 10'(V_TOT - 1);
  // hsync follows the shown pixels, so it may wrap past the line end
  localparam logic [9:0] HS_START = 10'((FETCH_LEAD + H_ACT + H_FP) % H_TOT);
  localparam logic [9:0] HS_STOP  = 10'((FETCH_LEAD + H_ACT + H_FP + H_S) % H_TOT);
  localparam logic [9:0] VS_START = 10'(V_ACT + V_FP);
  localparam logic [9:0] VS_STOP  = 10'(V_ACT + V_FP + V_S);

  logic [9:0]            hcnt;
  logic [9:0]            vcnt;
  logic                  line_end;
  logic                  frame_end;
  logic                  fetch_win;
  logic                  hs_now;
  logic                  vs_now;
  // display window is the fetch window seen FETCH_LEAD clocks later
  logic [FETCH_LEAD-1:0] win_dly;

  assign line_end  = hcnt == H_LAST;
  assign frame_end = line_end && vcnt == V_LAST;
  assign fetch_win = hcnt < 10'(H_ACT) && vcnt < 10'(V_ACT);

  assign hs_now = (HS_START < HS_STOP) ? (hcnt >= HS_START && hcnt < HS_STOP)
                                       : (hcnt >= HS_START || hcnt < HS_STOP);
  assign vs_now = vcnt >= VS_START && vcnt < VS_STOP;

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      hcnt    <= '0;
      vcnt    <= '0;
      win_dly <= '0;
      hs_raw  <= 1'b0;
      vs_raw  <= 1'b0;
    end else begin
      hcnt <= line_end ? 10'd0 : hcnt + 10'd1;
      if (frame_end) begin
        vcnt <= '0;
      end else if (line_end) begin
        vcnt <= vcnt + 10'd1;
      end
      win_dly <= {win_dly[FETCH_LEAD-2:0], fetch_win};
      // one stage to line up with the plane shifter output
      hs_raw <= hs_now;
      vs_raw <= vs_now;
    end
  end

  assign raster = '{
    hcnt:      hcnt,
    vcnt:      vcnt,
    de:        win_dly[FETCH_LEAD-1],
    line_end:  line_end,
    frame_end: frame_end
  };

endmodule

`default_nettype wire

// ==== hw/word_fetch.sv ====
/*
 * Bit plane word fetcher.
 * Issues one read strobe per word at the start of each group, steps the
 * video address and files returned words into two group banks, so that
 * the shifter always finds the group it is about to show.
 */
`default_nettype none

module word_fetch import shifter_pkg::*; #(
  parameter int H_ACT = 640,
  parameter int V_ACT = 400
) (
  input  logic        clk,
  input  logic        ss,
  input  raster_t     raster,
  input  shmode_t     mode,
  input  vaddr_t      base_addr,
  input  word_t       data,
  output logic        read,
  output vaddr_t      vaddr,
  output word_t [3:0] group
);

  logic        low;
  logic        med;
  logic        fetch_win;
  logic [4:0]  grp_pos;
  logic [4:0]  last_read;
  logic        want;
  // request side, registered with the strobe
  logic [1:0]  req_slot;
  logic        req_bank;
  // data return side, one cycle after the strobe
  logic        cap;
  logic [1:0]  cap_slot;
  logic        cap_bank;
  logic        fill_bank;
  logic        show_bank;
  logic [9:0]  disp_pos;
  logic        load;
  logic        restart;
  word_t [3:0] bank_buf [2];

  assign low = mode == MODE_LOW;
  assign med = mode == MODE_MED;

  // groups are aligned to hcnt, 32 clocks in low, 16 otherwise
  assign fetch_win = raster.hcnt < 10'(H_ACT) && raster.vcnt < 10'(V_ACT);
  assign grp_pos   = low ? raster.hcnt[4:0] : {1'b0, raster.hcnt[3:0]};
  assign last_read = low ? 5'd3 : (med ? 5'd1 : 5'd0);
  assign want      = fetch_win && grp_pos <= last_read;

  // same load points as the plane shifter, counted over de
  assign load = raster.de && (low ? disp_pos[4:0] == 5'd0 : disp_pos[3:0] == 4'd0);

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      read      <= 1'b0;
      req_slot  <= '0;
      req_bank  <= 1'b0;
      cap       <= 1'b0;
      cap_slot  <= '0;
      cap_bank  <= 1'b0;
      fill_bank <= 1'b0;
      show_bank <= 1'b0;
      disp_pos  <= '0;
      restart   <= 1'b1;
    end else begin
      restart  <= 1'b0;
      read     <= want;
      req_slot <= grp_pos[1:0];
      req_bank <= fill_bank;
      cap      <= read;
      cap_slot <= req_slot;
      cap_bank <= req_bank;
      disp_pos <= raster.de ? disp_pos + 10'd1 : 10'd0;
      if (raster.frame_end) begin
        // nothing is in flight between frames
        fill_bank <= 1'b0;
        show_bank <= 1'b0;
      end else begin
        // last read of a group moves fetch to the other bank
        if (want && grp_pos == last_read) begin
          fill_bank <= !fill_bank;
        end
        if (load) begin
          show_bank <= !show_bank;
        end
      end
    end
  end

  // address counter, reloaded after reset and at each frame end
  always_ff @(posedge clk) begin
    if (restart || raster.frame_end) begin
      vaddr <= base_addr;
    end else if (read) begin
      vaddr <= vaddr + 23'd1;
    end
  end

  // memory answers one cycle after the strobe
  always_ff @(posedge clk) begin
    if (cap) begin
      bank_buf[cap_bank][cap_slot] <= data;
    end
  end

  assign group = bank_buf[show_bank];

endmodule

`default_nettype wire

// ==== hw/plane_shifter.sv ====
/*
 * Plane shift registers.
 * Loads a group of plane words at each group start inside the display
 * window and shifts them out MSB first as 4 bit colour indexes.
 * Low res holds each pixel for two clocks.
 */
`default_nettype none

module plane_shifter import shifter_pkg::*; (
  input  logic        clk,
  input  logic        ss,
  input  raster_t     raster,
  input  shmode_t     mode,
  input  word_t [3:0] group,
  output color_idx_t  index,
  output logic        de_pix
);

  logic        low;
  logic        med;
  // pixel position inside the current display line
  logic [9:0]  pos;
  logic        load;
  logic        step;
  word_t [3:0] plane;

  assign low = mode == MODE_LOW;
  assign med = mode == MODE_MED;

  // new group every 32 pixels in low, every 16 in mono and medium
  assign load = raster.de && (low ? pos[4:0] == 5'd0 : pos[3:0] == 4'd0);
  // low res shifts on even positions only
  assign step = raster.de && (!low || !pos[0]);

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      pos    <= '0;
      de_pix <= 1'b0;
    end else begin
      pos    <= raster.de ? pos + 10'd1 : 10'd0;
      de_pix <= raster.de;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      plane[0] <= group[0];
      // planes a mode does not use stay zero
      plane[1] <= (low || med) ? group[1] : '0;
      plane[2] <= low ? group[2] : '0;
      plane[3] <= low ? group[3] : '0;
    end else if (step) begin
      plane[0] <= {plane[0][14:0], 1'b0};
      plane[1] <= {plane[1][14:0], 1'b0};
      plane[2] <= {plane[2][14:0], 1'b0};
      plane[3] <= {plane[3][14:0], 1'b0};
    end
  end

  // plane 0 is the index lsb
  assign index = {plane[3][15], plane[2][15], plane[1][15], plane[0][15]};

endmodule

`default_nettype wire

// ==== hw/palette_out.sv ====
/*
 * Palette output stage.
 * Maps colour indexes through the palette, or to black and white in mono,
 * fills the border and registers colour, display enable and active low syncs.
 */
`default_nettype none

module palette_out import shifter_pkg::*; (
  input  logic       clk,
  input  logic       ss,
  input  color_idx_t index,
  input  logic       de_pix,
  input  shmode_t    mode,
  input  palette_t   palette,
  input  logic       hs_raw,
  input  logic       vs_raw,
  output rgb_t       rgb,
  output logic       de,
  output logic       hs,
  output logic       vs
);

  logic mono;
  logic mono_bit;
  rgb_t pix;

  // mode 3 falls into mono
  assign mono     = !(mode == MODE_LOW || mode == MODE_MED);
  // entry 0 blue lsb inverts the mono picture
  assign mono_bit = index[0] ^ palette[0].b[0];

  always_comb begin
    if (mono) begin
      // mono border is black
      pix = (de_pix && mono_bit) ? '{r: 3'd7, g: 3'd7, b: 3'd7} : '0;
    end else begin
      pix = de_pix ? palette[index] : palette[0];
    end
  end

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      rgb <= '0;
      de  <= 1'b0;
      hs  <= 1'b1;
      vs  <= 1'b1;
    end else begin
      rgb <= pix;
      de  <= de_pix;
      hs  <= !hs_raw;
      vs  <= !vs_raw;
    end
  end

endmodule

`default_nettype wire

// ==== hw/video_shifter.sv ====
/*
 * Top level of the video shifter pixel path.
 * Sets the raster geometry and reset defaults and chains register file,
 * timing, fetcher, plane shifter and palette stage on one pixel clock.
 * H_ACT must be a multiple of 32.
 */
`default_nettype none

module video_shifter import shifter_pkg::*; #(
  parameter int      H_ACT        = 640,
  parameter int      H_FP         = 24,
  parameter int      H_S          = 40,
  parameter int      H_BP         = 128,
  parameter int      V_ACT        = 400,
  parameter int      V_FP         = 55,
  parameter int      V_S          = 3,
  parameter int      V_BP         = 73,
  parameter vaddr_t  BASE_ADDR    = 23'h8000,
  parameter shmode_t DEFAULT_MODE = MODE_MONO
) (
  input  logic     clk,
  input  logic     ss,
  // cpu registers
  input  reg_bus_t reg_bus,
  output word_t    reg_dout,
  // video memory
  output logic     read,
  output vaddr_t   vaddr,
  input  word_t    data,
  // screen
  output rgb_t     rgb,
  output logic     hs,
  output logic     vs,
  output logic     de
);

  raster_t     raster;
  logic        hs_raw;
  logic        vs_raw;
  shmode_t     mode;
  vaddr_t      base_addr;
  palette_t    palette;
  word_t [3:0] group;
  color_idx_t  index;
  logic        de_pix;

  shifter_regs #(
    .BASE_ADDR    (BASE_ADDR),
    .DEFAULT_MODE (DEFAULT_MODE)
  ) u_regs (
    .clk       (clk),
    .ss        (ss),
    .reg_bus   (reg_bus),
    .vaddr     (vaddr),
    .frame_end (raster.frame_end),
    .reg_dout  (reg_dout),
    .base_addr (base_addr),
    .mode      (mode),
    .palette   (palette)
  );

  raster_timing #(
    .H_ACT (H_ACT), .H_FP (H_FP), .H_S (H_S), .H_BP (H_BP),
    .V_ACT (V_ACT), .V_FP (V_FP), .V_S (V_S), .V_BP (V_BP)
  ) u_timing (
    .clk    (clk),
    .ss     (ss),
    .raster (raster),
    .hs_raw (hs_raw),
    .vs_raw (vs_raw)
  );

  word_fetch #(
    .H_ACT (H_ACT),
    .V_ACT (V_ACT)
  ) u_fetch (
    .clk       (clk),
    .ss        (ss),
    .raster    (raster),
    .mode      (mode),
    .base_addr (base_addr),
    .data      (data),
    .read      (read),
    .vaddr     (vaddr),
    .group     (group)
  );

  plane_shifter u_shifter (
    .clk    (clk),
    .ss     (ss),
    .raster (raster),
    .mode   (mode),
    .group  (group),
    .index  (index),
    .de_pix (de_pix)
  );

  palette_out u_out (
    .clk     (clk),
    .ss      (ss),
    .index   (index),
    .de_pix  (de_pix),
    .mode    (mode),
    .palette (palette),
    .hs_raw  (hs_raw),
    .vs_raw  (vs_raw),
    .rgb     (rgb),
    .de      (de),
    .hs      (hs),
    .vs      (vs)
  );

endmodule

`default_nettype wire

// ==== testbench/video_checker.sv ====
/*
 * Bound assertions on the video shifter outputs.
 * Attached to every video_shifter instance through bind.
 */
`default_nettype none

module video_checker import shifter_pkg::*; (
  input logic    clk,
  input logic    ss,
  input logic    read,
  input logic    de,
  input logic    hs,
  input logic    vs,
  input rgb_t    rgb,
  input shmode_t mode
);

  logic mono;

  assign mono = !(mode == MODE_LOW || mode == MODE_MED);

  // no memory traffic in reset
  assert property (@(posedge clk) ss |-> !read)
    else $error("read strobe during reset");

  // syncs sit outside the display window
  assert property (@(posedge clk) disable iff (ss) de |-> (hs && vs))
    else $error("de high during sync");

  // output lags the mode by one register stage
  assert property (@(posedge clk) disable iff (ss)
    (!de && mono && $past(mono)) |-> rgb == '0)
    else $error("mono border not black");

endmodule

bind video_shifter video_checker chk0 (
  .clk  (clk),
  .ss   (ss),
  .read (read),
  .de   (de),
  .hs   (hs),
  .vs   (vs),
  .rgb  (rgb),
  .mode (mode)
);

`default_nettype wire

// ==== testbench/tb_video.sv ====
/*
 * Directed testbench for the video shifter.
 * Runs a small raster geometry against a table memory model and checks
 * reset state, register access, mono, low and medium pixels, border and sync.
 */
`default_nettype none

module tb_video import shifter_pkg::*;;

  localparam vaddr_t BASE = 23'h8000;
  localparam int H_TOT = 80;
  localparam int V_TOT = 8;

  logic     clk;
  logic     ss;
  reg_bus_t reg_bus;
  word_t    reg_dout;
  logic     read;
  vaddr_t   vaddr;
  word_t    data;
  rgb_t     rgb;
  logic     hs;
  logic     vs;
  logic     de;

  // expected state, kept from the register rules
  word_t    mem [4096];
  palette_t pal_sh;
  vaddr_t   base_sh;
  shmode_t  mode_now;
  int       errors;
  int       timeouts;
  int       seed;
  int       r;

  video_shifter #(
    .H_ACT (64), .H_FP (4), .H_S (4), .H_BP (8),
    .V_ACT (4), .V_FP (1), .V_S (1), .V_BP (2),
    .BASE_ADDR (BASE), .DEFAULT_MODE (MODE_MONO)
  ) dut0 (
    .clk (clk), .ss (ss), .reg_bus (reg_bus), .reg_dout (reg_dout),
    .read (read), .vaddr (vaddr), .data (data),
    .rgb (rgb), .hs (hs), .vs (vs), .de (de)
  );

  always #2 clk = !clk;

  // memory answers each strobe on the next cycle
  always @(posedge clk) begin
    vaddr_t a;
    if (read) begin
      a = vaddr;
      #1;
      data = mem[a[11:0]];
    end
  end

  task check_rgb(input rgb_t got, input rgb_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error t=%0t: %s rgb %o expected %o", $time, what, got, exp);
    end
  endtask

  task check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error t=%0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task check_vaddr(input vaddr_t got, input vaddr_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error t=%0t: %s vaddr %h expected %h", $time, what, got, exp);
    end
  endtask

  task check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error t=%0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task wait_de(input logic val);
    int n;
    for (n = 0; n < 2000; n++) begin
      @(negedge clk);
      if (de === val) return;
    end
    timeouts++;
    $display("timeout: display enable never became %0b", val);
  endtask

  task wait_vs(input logic val);
    int n;
    for (n = 0; n < 2000; n++) begin
      @(negedge clk);
      if (vs === val) return;
    end
    timeouts++;
    $display("timeout: vertical sync never became %0b", val);
  endtask

  // returns at the start of a vsync pulse, next de is line 0 of a new frame
  task wait_frame();
    wait_vs(1'b1);
    wait_vs(1'b0);
  endtask

  task write_reg(input logic [5:0] addr, input logic uds, input logic lds, input word_t din);
    @(posedge clk);
    #1 reg_bus = '{sel: 1'b1, rw: 1'b0, addr: addr, uds: uds, lds: lds, din: din};
    @(posedge clk);
    #1 reg_bus = '0;
  endtask

  task read_reg(input logic [5:0] addr, output word_t d);
    @(posedge clk);
    #1 reg_bus = '{sel: 1'b1, rw: 1'b1, addr: addr, uds: 1'b0, lds: 1'b0, din: 16'h0};
    @(negedge clk);
    d = reg_dout;
    @(posedge clk);
    #1 reg_bus = '0;
  endtask

  function automatic word_t pal_word(input rgb_t c);
    return {5'b0, c.r, 1'b0, c.g, 1'b0, c.b};
  endfunction

  // pixel k of display line ln, from the fetch order and plane rules
  function automatic rgb_t expect_pixel(input shmode_t m, input int ln, input int k);
    vaddr_t     a;
    color_idx_t idx;
    int         bitn;
    int         p;
    logic       bt;
    idx = '0;
    if (m == MODE_MONO) begin
      a = base_sh + vaddr_t'(ln * 4 + k / 16);
      bt = mem[a[11:0]][15 - k % 16] ^ pal_sh[0].b[0];
      return bt ? rgb_t'(9'o777) : rgb_t'(9'o000);
    end
    if (m == MODE_LOW) begin
      bitn = 15 - (k % 32) / 2;
      for (p = 0; p < 4; p++) begin
        a = base_sh + vaddr_t'(ln * 8 + (k / 32) * 4 + p);
        idx[p] = mem[a[11:0]][bitn];
      end
    end else begin
      bitn = 15 - k % 16;
      for (p = 0; p < 2; p++) begin
        a = base_sh + vaddr_t'(ln * 8 + (k / 16) * 2 + p);
        idx[p] = mem[a[11:0]][bitn];
      end
    end
    return pal_sh[idx];
  endfunction

  function automatic rgb_t border_color(input shmode_t m);
    return (m == MODE_MONO) ? rgb_t'(9'o000) : pal_sh[0];
  endfunction

  task test_reset();
    word_t d;
    int    i;
    check_bit(read, 1'b0, "reset read");
    check_bit(de, 1'b0, "reset de");
    check_bit(hs, 1'b1, "reset hs");
    check_bit(vs, 1'b1, "reset vs");
    read_reg(REG_BASE_HI, d);
    check_word(d, {8'h00, BASE[22:15]}, "reset base hi");
    read_reg(REG_BASE_LO, d);
    check_word(d, {8'h00, BASE[14:7]}, "reset base lo");
    read_reg(REG_MODE, d);
    check_word(d, {6'h00, MODE_MONO, 8'h00}, "reset mode");
    for (i = 0; i < 16; i++) begin
      read_reg(REG_PAL_FIRST + 6'(i), d);
      check_word(d, pal_word(pal_sh[i]), "reset palette");
    end
  endtask

  task test_regs();
    word_t d;
    write_reg(REG_BASE_HI, 1'b1, 1'b0, 16'h0001);
    write_reg(REG_BASE_LO, 1'b1, 1'b0, 16'h0002);
    base_sh = {8'h01, 8'h02, 7'd0};
    read_reg(REG_BASE_HI, d);
    check_word(d, 16'h0001, "base hi readback");
    read_reg(REG_BASE_LO, d);
    check_word(d, 16'h0002, "base lo readback");
    // upper lane only, low byte must be ignored
    write_reg(REG_PAL_FIRST + 6'd5, 1'b0, 1'b1, 16'h02ff);
    pal_sh[5].r = 3'd2;
    read_reg(REG_PAL_FIRST + 6'd5, d);
    check_word(d, pal_word(pal_sh[5]), "palette red lane");
    // lower lane only, red bits ignored
    write_reg(REG_PAL_FIRST + 6'd5, 1'b1, 1'b0, 16'h0516);
    pal_sh[5].g = 3'd1;
    pal_sh[5].b = 3'd6;
    read_reg(REG_PAL_FIRST + 6'd5, d);
    check_word(d, pal_word(pal_sh[5]), "palette green blue lane");
  endtask

  // entry 0 blue lsb selects inverted mono
  task set_mono_invert(input logic inv);
    rgb_t c;
    c = pal_sh[0];
    c.b[0] = inv;
    write_reg(REG_PAL_FIRST, 1'b1, 1'b0, pal_word(c));
    pal_sh[0] = c;
  endtask

  // mono fetches 4 words per line over 4 lines
  task test_addresses();
    int n;
    int t;
    wait_frame();
    for (n = 0; n < 16; n++) begin
      for (t = 0; t < 2000 && read !== 1'b1; t++) @(negedge clk);
      if (read !== 1'b1) begin
        timeouts++;
        $display("timeout: no memory read seen for word %0d", n);
        return;
      end
      check_vaddr(vaddr, base_sh + vaddr_t'(n), "fetch address");
      @(negedge clk);
    end
  endtask

  task check_frame(input shmode_t m);
    int ln;
    int k;
    wait_frame();
    for (ln = 0; ln < 4; ln++) begin
      wait_de(1'b1);
      for (k = 0; k < 64; k++) begin
        if (k > 0) @(negedge clk);
        check_bit(de, 1'b1, "de inside line");
        check_rgb(rgb, expect_pixel(m, ln, k), "pixel");
      end
    end
  endtask

  // new mode must not show before the frame ends
  task test_mode_latch(input shmode_t m);
    word_t d;
    int    t;
    wait_frame();
    wait_de(1'b1);
    write_reg(REG_MODE, 1'b0, 1'b1, {6'h00, m, 8'h00});
    read_reg(REG_MODE, d);
    check_word(d, {6'h00, m, 8'h00}, "mode readback");
    for (t = 0; t < 2000 && vs !== 1'b0; t++) begin
      @(negedge clk);
      if (!de) check_rgb(rgb, border_color(mode_now), "border before mode switch");
    end
    if (vs !== 1'b0) begin
      timeouts++;
      $display("timeout: no vertical sync after the mode write");
    end
    mode_now = m;
  endtask

  task test_border_sync();
    int   t;
    int   hs_falls;
    int   vs_falls;
    logic hs_q;
    logic vs_q;
    hs_falls = 0;
    vs_falls = 0;
    wait_frame();
    hs_q = hs;
    vs_q = vs;
    // one whole frame, the next vsync start lands on the last sample
    for (t = 0; t < H_TOT * V_TOT; t++) begin
      @(negedge clk);
      if (!de) check_rgb(rgb, pal_sh[0], "colour border");
      if (hs_q && !hs) hs_falls++;
      if (vs_q && !vs) vs_falls++;
      hs_q = hs;
      vs_q = vs;
    end
    check_word(word_t'(hs_falls), word_t'(V_TOT), "hsync pulses per frame");
    check_word(word_t'(vs_falls), 16'd1, "vsync pulses per frame");
  endtask

  initial begin
    int i;
    clk = 1'b0;
    ss = 1'b1;
    reg_bus = '0;
    data = '0;
    errors = 0;
    timeouts = 0;
    seed = 99188;
    pal_sh = DEFAULT_PALETTE;
    base_sh = BASE;
    mode_now = MODE_MONO;
    for (i = 0; i < 4096; i++) begin
      r = $random(seed);
      mem[i] = r[15:0];
    end
    repeat (10) @(posedge clk);
    #1 ss = 1'b0;
    @(negedge clk);
    test_reset();
    test_regs();
    test_addresses();
    check_frame(MODE_MONO);
    set_mono_invert(1'b0);
    check_frame(MODE_MONO);
    test_mode_latch(MODE_LOW);
    check_frame(MODE_LOW);
    test_border_sync();
    test_mode_latch(MODE_MED);
    check_frame(MODE_MED);
    $display("errors: %0d wrong values, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/shifter_pkg.sv
hw/shifter_regs.sv
hw/raster_timing.sv
hw/word_fetch.sv
hw/plane_shifter.sv
hw/palette_out.sv
hw/video_shifter.sv
testbench/video_checker.sv
testbench/tb_video.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module tb_video -o sim_video
./obj_dir/sim_video | tee sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0
